/* logic/dma_pkg.sv */
//########################################
// shared definitions for the dma
// register map, descriptor layout,
// engine states, ccr/ndar write word
//########################################
package dma_pkg;

   // register word offsets, slave address bits 6:2
   localparam logic [4:0] REG_CCR    = 5'd0;
   localparam logic [4:0] REG_STATUS = 5'd1;
   localparam logic [4:0] REG_DAR    = 5'd2;
   localparam logic [4:0] REG_NDAR   = 5'd3;
   localparam logic [4:0] REG_SRC    = 5'd4;
   localparam logic [4:0] REG_DST    = 5'd5;
   localparam logic [4:0] REG_COUNT  = 5'd6;
   localparam logic [4:0] REG_SPI    = 5'd7;
   localparam logic [4:0] REG_ID     = 5'd8;

   localparam int REG_SEL_BIT = 10;              // must be set for a register hit
   localparam logic [31:0] ID_VALUE = 32'h0000aa55;

   // control word bits
   localparam int CCR_APPEND_BIT    = 0;
   localparam int CCR_ENABLE_BIT    = 1;
   localparam int CCR_INT_CLEAR_BIT = 2;
   localparam int CCR_INT_EN_BIT    = 30;
   localparam int CCR_SYS_RST_BIT   = 31;

   // descriptor word 2: flags and length in words
   localparam int DESC_LAST_BIT = 31;
   localparam int DESC_INT_BIT  = 30;
   localparam int DESC_LEN_W    = 16;
   localparam logic [31:0] DESC_NEXT_OFS = 32'd12; // byte offset of word 3

   // one write word, decoded as ccr fields or as ndar
   typedef union packed {
      struct packed {
         logic        sys_rst;
         logic        int_en;
         logic [26:0] rsvd;
         logic        int_clear;
         logic        enable;
         logic        append;
      } ccr;
      struct packed {
         logic [28:0] addr;  // 8-byte aligned descriptor
         logic [2:0]  low;
      } ndar;
   } ccr_word_u;

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_DESC_RD,
      ST_SRC_RD,
      ST_DST_WR,
      ST_NEXT,
      ST_ERR
   } sg_state_e;

endpackage

/* logic/dma_csr.sv */
//########################################
// wishbone slave register block
// ccr, ndar, interrupt, spi pins and
// live engine state readback
//########################################
`timescale 1ns/1ps
module dma_csr
   import dma_pkg::*;
(
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   // wishbone slave
   input  logic                  wbs_cyc_i,
   input  logic                  wbs_stb_i,
   input  logic                  wbs_we_i,
   input  logic [3:0]            wbs_sel_i,
   input  logic [31:0]           wbs_adr_i,
   input  logic [31:0]           wbs_dat_i,
   output logic [31:0]           wbs_dat_o,
   output logic                  wbs_ack_o,
   output logic                  wbs_err_o,
   // bit-banged spi
   input  logic                  spi_di_i,
   output logic                  spi_sel_o,
   output logic                  spi_clk_o,
   output logic                  spi_do_o,
   // to the engine
   output logic                  enable_o,
   output logic                  append_o,
   output logic [31:3]           ndar_o,
   output logic                  ndar_dirty_o,
   output logic                  soft_rst_o,
   output logic                  wb_int_o,
   // from the engine
   input  logic                  ndar_dirty_clear_i,
   input  logic                  append_clear_i,
   input  logic                  desc_done_int_i,
   input  logic                  bus_err_i,
   input  logic                  busy_i,
   input  logic [31:0]           dar_i,
   input  logic [31:0]           cur_src_i,
   input  logic [31:0]           cur_dst_i,
   input  logic [DESC_LEN_W-1:0] count_i,
   input  sg_state_e             state_i
);

   logic      req;
   logic      hit;
   logic      access;
   logic      wr;
   logic      ccr_we;
   logic      ndar_we;
   logic      spi_we;
   logic      int_en;
   logic      sys_rst;
   logic      int_pend;
   logic      bus_err_flag;
   ccr_word_u wr_word;

   assign req     = wbs_cyc_i & wbs_stb_i;
   assign hit     = wbs_adr_i[REG_SEL_BIT];
   assign access  = req & ~(wbs_ack_o | wbs_err_o); // no response pending
   assign wr      = access & hit & wbs_we_i;         // lands with the ack edge
   assign wr_word = wbs_dat_i;

   assign ccr_we  = wr & (wbs_adr_i[6:2] == REG_CCR);
   assign ndar_we = wr & (wbs_adr_i[6:2] == REG_NDAR) & ~enable_o; // locked while running
   assign spi_we  = wr & (wbs_adr_i[6:2] == REG_SPI);

   assign soft_rst_o = wb_rst_i | sys_rst;
   assign wb_int_o   = int_pend & int_en;

   // single cycle response
   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
      begin
         wbs_ack_o <= 1'b0;
         wbs_err_o <= 1'b0;
      end
      else
      begin
         wbs_ack_o <= access & hit;
         wbs_err_o <= access & ~hit;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
      begin
         enable_o     <= 1'b0;
         append_o     <= 1'b0;
         int_en       <= 1'b0;
         sys_rst      <= 1'b0;
         int_pend     <= 1'b0;
         bus_err_flag <= 1'b0;
         ndar_dirty_o <= 1'b0;
         spi_sel_o    <= 1'b0;
         spi_clk_o    <= 1'b0;
         spi_do_o     <= 1'b0;
      end
      else
      begin
         if (ccr_we)
         begin
            enable_o <= wr_word.ccr.enable;
            int_en   <= wr_word.ccr.int_en;
            sys_rst  <= wr_word.ccr.sys_rst;
         end

         if (ccr_we)
            append_o <= wr_word.ccr.append;
         else if (append_clear_i)
            append_o <= 1'b0;           // engine took the appended link

         if (desc_done_int_i)
            int_pend <= 1'b1;
         else if (ccr_we && wr_word.ccr.int_clear)
            int_pend <= 1'b0;

         if (bus_err_i)
            bus_err_flag <= 1'b1;       // sticky
         else if (ccr_we && wr_word.ccr.enable)
            bus_err_flag <= 1'b0;

         if (ndar_we)
            ndar_dirty_o <= 1'b1;
         else if (ndar_dirty_clear_i)
            ndar_dirty_o <= 1'b0;

         if (spi_we)
         begin
            spi_sel_o <= wbs_dat_i[2];
            spi_clk_o <= wbs_dat_i[1];
            spi_do_o  <= wbs_dat_i[0];
         end
      end
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (ndar_we)
         ndar_o <= wr_word.ndar.addr;
   end

   // readback, held by the master while ack is high
   always_comb
   begin
      wbs_dat_o = '0;
      case (wbs_adr_i[6:2])
         REG_CCR:
         begin
            wbs_dat_o[CCR_APPEND_BIT]  = append_o;
            wbs_dat_o[CCR_ENABLE_BIT]  = enable_o;
            wbs_dat_o[CCR_INT_EN_BIT]  = int_en;
            wbs_dat_o[CCR_SYS_RST_BIT] = sys_rst;
         end
         REG_STATUS: wbs_dat_o = {20'b0, state_i, 5'b0, bus_err_flag, int_pend, busy_i};
         REG_DAR:    wbs_dat_o = dar_i;
         REG_NDAR:   wbs_dat_o = {ndar_o, 3'b000};
         REG_SRC:    wbs_dat_o = cur_src_i;
         REG_DST:    wbs_dat_o = cur_dst_i;
         REG_COUNT:  wbs_dat_o = {{(32-DESC_LEN_W){1'b0}}, count_i};
         REG_SPI:    wbs_dat_o = {28'b0, spi_di_i, spi_sel_o, spi_clk_o, spi_do_o};
         REG_ID:     wbs_dat_o = ID_VALUE;
         default:    wbs_dat_o = '0;
      endcase
   end

endmodule

/* logic/sg_engine.sv */
//########################################
// scatter-gather engine
// descriptor fetch, word copy, chain
// walk on a wishbone classic master
//########################################
`timescale 1ns/1ps
module sg_engine
   import dma_pkg::*;
(
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   input  logic                  soft_rst_i,
   // from the register block
   input  logic                  enable_i,
   input  logic                  append_i,
   input  logic [31:3]           ndar_i,
   input  logic                  ndar_dirty_i,
   // pulses and readback
   output logic                  ndar_dirty_clear_o,
   output logic                  append_clear_o,
   output logic                  desc_done_int_o,
   output logic                  bus_err_o,
   output logic                  busy_o,
   output logic [31:0]           dar_o,
   output logic [31:0]           cur_src_o,
   output logic [31:0]           cur_dst_o,
   output logic [DESC_LEN_W-1:0] count_o,
   output sg_state_e             state_o,
   // wishbone master
   output logic                  wbm_cyc_o,
   output logic                  wbm_stb_o,
   output logic                  wbm_we_o,
   output logic [31:0]           wbm_adr_o,
   output logic [31:0]           wbm_dat_o,
   input  logic [31:0]           wbm_dat_i,
   input  logic                  wbm_ack_i,
   input  logic                  wbm_err_i
);

   logic [1:0]  idx;        // descriptor word being fetched
   logic [31:0] next_desc;
   logic [31:0] next_w;
   logic [31:0] data_buf;
   logic        last;
   logic        irq;
   logic        ack;
   logic        start;
   logic        desc_end;
   logic        go_next;
   logic        go_append;

   assign busy_o    = (state_o != ST_IDLE) && (state_o != ST_ERR);
   assign wbm_cyc_o = busy_o;   // every busy state is a bus access
   assign wbm_stb_o = busy_o;
   assign wbm_we_o  = (state_o == ST_DST_WR);
   assign wbm_dat_o = data_buf;

   assign ack   = wbm_cyc_o & wbm_ack_i;
   assign start = !busy_o && enable_i && ndar_dirty_i;

   // last word written, or a zero length descriptor fully fetched
   assign desc_end = ack &&
                     ((state_o == ST_DST_WR && count_o == DESC_LEN_W'(1)) ||
                      (state_o == ST_DESC_RD && idx == 2'd3 && count_o == '0));

   // word 3 is still on the bus at the end of a zero length fetch
   assign next_w    = (state_o == ST_DESC_RD) ? wbm_dat_i : next_desc;
   assign go_next   = desc_end && !last && enable_i;
   assign go_append = desc_end && last && append_i && enable_i;

   always_comb
   begin
      case (state_o)
         ST_DESC_RD: wbm_adr_o = dar_o + {28'b0, idx, 2'b00};
         ST_SRC_RD:  wbm_adr_o = cur_src_o;
         ST_DST_WR:  wbm_adr_o = cur_dst_o;
         ST_NEXT:    wbm_adr_o = dar_o + DESC_NEXT_OFS; // re-read link
         default:    wbm_adr_o = dar_o;
      endcase
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
      begin
         state_o            <= ST_IDLE;
         idx                <= 2'd0;
         ndar_dirty_clear_o <= 1'b0;
         append_clear_o     <= 1'b0;
         desc_done_int_o    <= 1'b0;
         bus_err_o          <= 1'b0;
      end
      else if (soft_rst_i)
      begin
         state_o            <= ST_IDLE;
         idx                <= 2'd0;
         ndar_dirty_clear_o <= 1'b0;
         append_clear_o     <= 1'b0;
         desc_done_int_o    <= 1'b0;
         bus_err_o          <= 1'b0;
      end
      else
      begin
         ndar_dirty_clear_o <= 1'b0;
         append_clear_o     <= 1'b0;
         desc_done_int_o    <= 1'b0;
         bus_err_o          <= 1'b0;

         if (wbm_cyc_o && wbm_err_i)
         begin
            state_o   <= ST_ERR;   // held until the next start
            bus_err_o <= 1'b1;
         end
         else if (start)
         begin
            state_o            <= ST_DESC_RD;
            idx                <= 2'd0;
            ndar_dirty_clear_o <= 1'b1;
         end
         else if (desc_end)
         begin
            desc_done_int_o <= last | irq;
            if (go_next)
            begin
               state_o <= ST_DESC_RD;
               idx     <= 2'd0;
            end
            else if (go_append)
            begin
               state_o        <= ST_NEXT;
               append_clear_o <= 1'b1;
            end
            else
               state_o <= ST_IDLE;  // end of chain or disabled
         end
         else if (ack)
         begin
            case (state_o)
               ST_DESC_RD:
               begin
                  idx <= idx + 2'd1;
                  if (idx == 2'd3)
                     state_o <= ST_SRC_RD;
               end
               ST_SRC_RD: state_o <= ST_DST_WR;
               ST_DST_WR: state_o <= ST_SRC_RD;
               ST_NEXT:
               begin
                  state_o <= ST_DESC_RD;
                  idx     <= 2'd0;
               end
               default: state_o <= state_o;
            endcase
         end
      end
   end

   // descriptor and data payload
   always_ff @(posedge wb_clk_i)
   begin
      if (start)
         dar_o <= {ndar_i, 3'b000};
      else if (go_next)
         dar_o <= {next_w[31:3], 3'b000};
      else if (ack && state_o == ST_NEXT)
         dar_o <= {wbm_dat_i[31:3], 3'b000};  // appended descriptor

      if (ack)
      begin
         case (state_o)
            ST_DESC_RD:
            begin
               case (idx)
                  2'd0: cur_src_o <= wbm_dat_i;
                  2'd1: cur_dst_o <= wbm_dat_i;
                  2'd2:
                  begin
                     count_o <= wbm_dat_i[DESC_LEN_W-1:0];
                     last    <= wbm_dat_i[DESC_LAST_BIT];
                     irq     <= wbm_dat_i[DESC_INT_BIT];
                  end
                  default: next_desc <= wbm_dat_i;
               endcase
            end
            ST_SRC_RD: data_buf <= wbm_dat_i;
            ST_DST_WR:
            begin
               cur_src_o <= cur_src_o + 32'd4;
               cur_dst_o <= cur_dst_o + 32'd4;
               count_o   <= count_o - DESC_LEN_W'(1);
            end
            default: data_buf <= data_buf;
         endcase
      end
   end

endmodule

/* logic/dma_top.sv */
//########################################
// dma top level
// register block and engine between
// slave port, master port and spi pins
//########################################
`timescale 1ns/1ps
module dma_top
   import dma_pkg::*;
(
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   // wishbone slave
   input  logic        wbs_cyc_i,
   input  logic        wbs_stb_i,
   input  logic        wbs_we_i,
   input  logic [3:0]  wbs_sel_i,
   input  logic [31:0] wbs_adr_i,
   input  logic [31:0] wbs_dat_i,
   output logic [31:0] wbs_dat_o,
   output logic        wbs_ack_o,
   output logic        wbs_err_o,
   // wishbone master
   output logic        wbm_cyc_o,
   output logic        wbm_stb_o,
   output logic        wbm_we_o,
   output logic [31:0] wbm_adr_o,
   output logic [31:0] wbm_dat_o,
   input  logic [31:0] wbm_dat_i,
   input  logic        wbm_ack_i,
   input  logic        wbm_err_i,
   // spi and system
   output logic        spi_sel_o,
   output logic        spi_clk_o,
   output logic        spi_do_o,
   input  logic        spi_di_i,
   output logic        wb_int_o,
   output logic        sys_rst_o
);

   logic                  enable;
   logic                  append;
   logic [31:3]           ndar;
   logic                  ndar_dirty;
   logic                  ndar_dirty_clear;
   logic                  append_clear;
   logic                  desc_done_int;
   logic                  bus_err;
   logic                  busy;
   logic [31:0]           dar;
   logic [31:0]           cur_src;
   logic [31:0]           cur_dst;
   logic [DESC_LEN_W-1:0] count;
   sg_state_e             state;

   dma_csr csr_i (
      .wb_clk_i           (wb_clk_i),
      .wb_rst_i           (wb_rst_i),
      .wbs_cyc_i          (wbs_cyc_i),
      .wbs_stb_i          (wbs_stb_i),
      .wbs_we_i           (wbs_we_i),
      .wbs_sel_i          (wbs_sel_i),
      .wbs_adr_i          (wbs_adr_i),
      .wbs_dat_i          (wbs_dat_i),
      .wbs_dat_o          (wbs_dat_o),
      .wbs_ack_o          (wbs_ack_o),
      .wbs_err_o          (wbs_err_o),
      .spi_di_i           (spi_di_i),
      .spi_sel_o          (spi_sel_o),
      .spi_clk_o          (spi_clk_o),
      .spi_do_o           (spi_do_o),
      .enable_o           (enable),
      .append_o           (append),
      .ndar_o             (ndar),
      .ndar_dirty_o       (ndar_dirty),
      .soft_rst_o         (sys_rst_o),   // also resets the engine
      .wb_int_o           (wb_int_o),
      .ndar_dirty_clear_i (ndar_dirty_clear),
      .append_clear_i     (append_clear),
      .desc_done_int_i    (desc_done_int),
      .bus_err_i          (bus_err),
      .busy_i             (busy),
      .dar_i              (dar),
      .cur_src_i          (cur_src),
      .cur_dst_i          (cur_dst),
      .count_i            (count),
      .state_i            (state)
   );

   sg_engine engine_i (
      .wb_clk_i           (wb_clk_i),
      .wb_rst_i           (wb_rst_i),
      .soft_rst_i         (sys_rst_o),
      .enable_i           (enable),
      .append_i           (append),
      .ndar_i             (ndar),
      .ndar_dirty_i       (ndar_dirty),
      .ndar_dirty_clear_o (ndar_dirty_clear),
      .append_clear_o     (append_clear),
      .desc_done_int_o    (desc_done_int),
      .bus_err_o          (bus_err),
      .busy_o             (busy),
      .dar_o              (dar),
      .cur_src_o          (cur_src),
      .cur_dst_o          (cur_dst),
      .count_o            (count),
      .state_o            (state),
      .wbm_cyc_o          (wbm_cyc_o),
      .wbm_stb_o          (wbm_stb_o),
      .wbm_we_o           (wbm_we_o),
      .wbm_adr_o          (wbm_adr_o),
      .wbm_dat_o          (wbm_dat_o),
      .wbm_dat_i          (wbm_dat_i),
      .wbm_ack_i          (wbm_ack_i),
      .wbm_err_i          (wbm_err_i)
   );

endmodule

/* verification/tb_clock.sv */
//########################################
// testbench clock source, 20 ns period
//########################################
`timescale 1ns/1ps
module tb_clock
(
   output logic clk_o
);

   localparam int HALF_NS = 10;

   initial
   begin
      clk_o = 1'b0;
      forever
      begin
         #(HALF_NS) clk_o = ~clk_o;
      end
   end

endmodule

/* verification/wb_mem_model.sv */
//########################################
// wishbone word memory slave
// lfsr wait states, err window at
// byte addresses 0xc000 to 0xffff
//########################################
`timescale 1ns/1ps
module wb_mem_model
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [31:0] adr_i,
   input  logic [31:0] dat_i,
   output logic [31:0] dat_o,
   output logic        ack_o,
   output logic        err_o
);

   logic [31:0] mem [0:4095];   // 16 kB, also loaded by the testbench
   logic [15:0] lfsr_q;
   logic [1:0]  wait_q;

   // fibonacci lfsr, taps 16 14 13 11, one step per bit
   function automatic logic [1:0] next_wait();
      logic [1:0] val;
      logic       fb;
      val = 2'b00;
      for (int i = 0; i < 2; i++)
      begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         val    = {val[0], fb};
      end
      return val;
   endfunction

   always @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         ack_o  <= 1'b0;
         err_o  <= 1'b0;
         wait_q <= 2'd0;
         dat_o  <= 32'd0;
         lfsr_q = 16'd25;
      end
      else
      begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
         if (cyc_i && stb_i && !ack_o && !err_o)
         begin
            if (wait_q != 2'd0)
               wait_q <= wait_q - 2'd1;   // back-pressure
            else
            begin
               if (adr_i[15:14] == 2'b11)
                  err_o <= 1'b1;
               else
               begin
                  ack_o <= 1'b1;
                  if (we_i)
                     mem[adr_i[13:2]] = dat_i;
                  else
                     dat_o <= mem[adr_i[13:2]];
               end
               wait_q <= next_wait();
            end
         end
      end
   end

endmodule

/* verification/dma_tb.sv */
//########################################
// dma testbench top
// reference copy, register tasks,
// checker, watchdog, test sequence
//########################################
`timescale 1ns/1ps
module dma_tb
   import dma_pkg::*;
();

   localparam int MAX_WORDS       = 120;
   localparam int WATCHDOG_CYCLES = MAX_WORDS * 200 + 5000;
   localparam int CLK_NS          = 20;

   logic        clk;
   logic        rst;
   logic        wbs_cyc, wbs_stb, wbs_we;
   logic [3:0]  wbs_sel;
   logic [31:0] wbs_adr, wbs_wdat, wbs_rdat;
   logic        wbs_ack, wbs_err;
   logic        wbm_cyc, wbm_stb, wbm_we;
   logic [31:0] wbm_adr, wbm_wdat, wbm_rdat;
   logic        wbm_ack, wbm_err;
   logic        spi_sel, spi_clk, spi_do, spi_di;
   logic        wb_int, sys_rst;

   logic [31:0] img [0:4095];   // expected memory contents
   logic [15:0] lfsr_q;
   int          err_count;

   tb_clock clk_gen_i (.clk_o(clk));

   dma_top dma_top_i (
      .wb_clk_i(clk), .wb_rst_i(rst),
      .wbs_cyc_i(wbs_cyc), .wbs_stb_i(wbs_stb), .wbs_we_i(wbs_we), .wbs_sel_i(wbs_sel),
      .wbs_adr_i(wbs_adr), .wbs_dat_i(wbs_wdat), .wbs_dat_o(wbs_rdat),
      .wbs_ack_o(wbs_ack), .wbs_err_o(wbs_err),
      .wbm_cyc_o(wbm_cyc), .wbm_stb_o(wbm_stb), .wbm_we_o(wbm_we), .wbm_adr_o(wbm_adr),
      .wbm_dat_o(wbm_wdat), .wbm_dat_i(wbm_rdat), .wbm_ack_i(wbm_ack), .wbm_err_i(wbm_err),
      .spi_sel_o(spi_sel), .spi_clk_o(spi_clk), .spi_do_o(spi_do), .spi_di_i(spi_di),
      .wb_int_o(wb_int), .sys_rst_o(sys_rst)
   );

   wb_mem_model mem_i (
      .clk_i(clk), .rst_i(rst), .cyc_i(wbm_cyc), .stb_i(wbm_stb), .we_i(wbm_we),
      .adr_i(wbm_adr), .dat_i(wbm_wdat), .dat_o(wbm_rdat), .ack_o(wbm_ack), .err_o(wbm_err)
   );

   // fibonacci lfsr, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = 32'd0;
      for (int i = 0; i < n; i++)
      begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         val    = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic logic [11:0] widx(input logic [31:0] a);
      return a[13:2];
   endfunction

   // walks the chain in img, returns the last descriptor address
   function automatic logic [31:0] dma_copy_ref(input logic [31:0] first, input bit append);
      logic [31:0] d, src, dst, fl;
      bit          done;
      d    = {first[31:3], 3'b000};
      done = 1'b0;
      while (!done)
      begin
         src = img[widx(d)];
         dst = img[widx(d + 32'd4)];
         fl  = img[widx(d + 32'd8)];
         for (int i = 0; i < int'(fl[DESC_LEN_W-1:0]); i++)
         begin
            if (src[15:14] == 2'b11 || dst[15:14] == 2'b11)
               return d;                // bus error ends the chain
            img[widx(dst)] = img[widx(src)];
            src = src + 32'd4;
            dst = dst + 32'd4;
         end
         if (!fl[DESC_LAST_BIT])
            d = {img[widx(d + 32'd12)][31:3], 3'b000};
         else if (append)
         begin
            append = 1'b0;
            d = {img[widx(d + 32'd12)][31:3], 3'b000};
         end
         else
            done = 1'b1;
      end
      return d;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         err_count++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         $display("sim failed");
         $fatal(1);
      end
   endtask

   task automatic report_error(input string msg);
      err_count++;
      $display("%s", msg);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat, output logic ack_seen,
                             output logic err_seen);
      int n;
      @(posedge clk);
      #1;
      wbs_cyc  = 1'b1;
      wbs_stb  = 1'b1;
      wbs_we   = we;
      wbs_adr  = adr;
      wbs_wdat = wdat;
      n = 0;
      do
      begin
         @(posedge clk);
         #1;
         n++;
      end while (!(wbs_ack || wbs_err) && n < 20);
      if (!(wbs_ack || wbs_err))
         report_error("register access got no response");
      rdat     = wbs_rdat;
      ack_seen = wbs_ack;
      err_seen = wbs_err;
      wbs_cyc  = 1'b0;
      wbs_stb  = 1'b0;
      wbs_we   = 1'b0;
   endtask

   function automatic logic [31:0] reg_adr(input logic [4:0] r);
      return 32'h400 | {25'd0, r, 2'b00};
   endfunction

   task automatic reg_write(input logic [4:0] r, input logic [31:0] d);
      logic [31:0] unused;
      logic        a, e;
      bus_access(1'b1, reg_adr(r), d, unused, a, e);
      if (e)
         report_error("register write answered with err");
   endtask

   task automatic reg_read(input logic [4:0] r, output logic [31:0] d);
      logic a, e;
      bus_access(1'b0, reg_adr(r), 32'd0, d, a, e);
      if (e)
         report_error("register read answered with err");
   endtask

   task automatic poke(input logic [31:0] adr, input logic [31:0] val);
      img[widx(adr)]       = val;
      mem_i.mem[widx(adr)] = val;
   endtask

   task automatic put_desc(input logic [31:0] adr, input logic [31:0] src,
                           input logic [31:0] dst, input logic [31:0] fl,
                           input logic [31:0] nxt);
      poke(adr, src);
      poke(adr + 32'd4, dst);
      poke(adr + 32'd8, fl);
      poke(adr + 32'd12, nxt);
   endtask

   task automatic fill_src(input logic [31:0] adr, input int n);
      for (int i = 0; i < n; i++)
         poke(adr + 32'(4 * i), rand_bits(32));
   endtask

   task automatic start_chain(input logic [31:0] desc, input logic [31:0] bits);
      reg_write(REG_CCR, 32'd0);
      reg_write(REG_NDAR, desc);
      reg_write(REG_CCR, bits | (32'd1 << CCR_ENABLE_BIT) | (32'd1 << CCR_INT_CLEAR_BIT));
   endtask

   // interrupt and error flags land a cycle after busy drops
   task automatic wait_idle(output logic [31:0] st);
      do
         reg_read(REG_STATUS, st);
      while (st[0]);
      reg_read(REG_STATUS, st);
   endtask

   // returns once the descriptor is fetched and words are moving
   task automatic wait_copy_phase();
      logic [31:0] st;
      do
         reg_read(REG_STATUS, st);
      while (st[0] && st[11:8] == 4'(ST_DESC_RD));
   endtask

   // whole memory against the reference image
   task automatic compare_mem();
      for (int i = 0; i < 4096; i++)
         check_value($sformatf("mem[%0h]", i * 4), mem_i.mem[i], img[i]);
   endtask

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_NS);
      $display("watchdog expired before the tests finished");
      $display("sim failed");
      $fatal(1);
   end

   initial
   begin
      logic [31:0] d, st, last_d;
      logic        a, e;
      int          n0, n1, n2;
      err_count = 0;
      lfsr_q    = 16'd25;
      rst       = 1'b1;
      wbs_cyc   = 1'b0;
      wbs_stb   = 1'b0;
      wbs_we    = 1'b0;
      wbs_sel   = 4'hf;
      wbs_adr   = 32'd0;
      wbs_wdat  = 32'd0;
      spi_di    = 1'b0;
      for (int i = 0; i < 4096; i++)
      begin
         img[i]       = {4'ha, i[11:0], 4'h5, ~i[11:0]};  // whole address in the word
         mem_i.mem[i] = img[i];
      end
      repeat (8) @(posedge clk);
      #1 rst = 1'b0;

      // reset values and the err decode
      reg_read(REG_ID, d);
      check_value("id", d, ID_VALUE);
      reg_read(REG_STATUS, d);
      check_value("status", d, 32'd0);
      reg_read(REG_CCR, d);
      check_value("ccr", d, 32'd0);
      check_value("wb_int_o", 32'(wb_int), 32'd0);
      check_value("sys_rst_o", 32'(sys_rst), 32'd0);
      check_value("spi pins", {29'd0, spi_sel, spi_clk, spi_do}, 32'd0);
      check_value("wbm_cyc_o", 32'(wbm_cyc), 32'd0);
      check_value("wbm_stb_o", 32'(wbm_stb), 32'd0);
      bus_access(1'b0, 32'h0000_0004, 32'd0, d, a, e);
      check_value("wbs_err_o", 32'(e), 32'd1);
      check_value("wbs_ack_o", 32'(a), 32'd0);

      // ndar lock and spi pins
      put_desc(32'h200, 32'h1000, 32'h2000, 32'h8000_0000, 32'd0);
      reg_write(REG_NDAR, 32'h207);
      reg_read(REG_NDAR, d);
      check_value("ndar", d, 32'h200);
      reg_write(REG_CCR, 32'd1 << CCR_ENABLE_BIT);   // walks the empty descriptor
      reg_write(REG_NDAR, 32'h2000);
      reg_read(REG_NDAR, d);
      check_value("ndar locked", d, 32'h200);
      wait_idle(st);
      reg_write(REG_SPI, 32'h5);
      spi_di = 1'b1;
      check_value("spi pins", {29'd0, spi_sel, spi_clk, spi_do}, 32'h5);
      reg_read(REG_SPI, d);
      check_value("spi", d, 32'hd);

      // single descriptor with interrupt
      fill_src(32'h1300, 8);
      put_desc(32'h300, 32'h1300, 32'h2300, 32'hc000_0008, 32'd0);
      start_chain(32'h300, 32'd1 << CCR_INT_EN_BIT);
      wait_idle(st);
      last_d = dma_copy_ref(32'h300, 1'b0);
      compare_mem();
      check_value("status", st, 32'h0000_0002);   // idle, interrupt pending
      check_value("wb_int_o", 32'(wb_int), 32'd1);
      reg_write(REG_CCR, (32'd1 << CCR_INT_EN_BIT) | (32'd1 << CCR_INT_CLEAR_BIT));
      check_value("wb_int_o", 32'(wb_int), 32'd0);

      // three descriptor chain
      n0 = int'(rand_bits(4)) + 1;
      n1 = int'(rand_bits(4)) + 1;
      n2 = int'(rand_bits(4)) + 1;
      fill_src(32'h1000, n0);
      fill_src(32'h1100, n1);
      fill_src(32'h1200, n2);
      put_desc(32'h100, 32'h1000, 32'h2000, 32'(n0), 32'h120);
      put_desc(32'h120, 32'h1100, 32'h2100, 32'(n1), 32'h140);
      put_desc(32'h140, 32'h1200, 32'h2200, 32'h8000_0000 | 32'(n2), 32'd0);
      start_chain(32'h100, 32'd0);
      wait_idle(st);
      last_d = dma_copy_ref(32'h100, 1'b0);
      compare_mem();
      reg_read(REG_DAR, d);
      check_value("dar", d, last_d);

      // append a descriptor while the chain runs
      fill_src(32'h1400, 16);
      n0 = int'(rand_bits(4)) + 1;
      fill_src(32'h1500, n0);
      put_desc(32'h400, 32'h1400, 32'h2400, 32'h8000_0010, 32'd0);
      put_desc(32'h420, 32'h1500, 32'h2500, 32'h8000_0000 | 32'(n0), 32'd0);
      start_chain(32'h400, 32'd1 << CCR_APPEND_BIT);
      wait_copy_phase();
      poke(32'h40c, 32'h420);   // link patched after the fetch
      wait_idle(st);
      last_d = dma_copy_ref(32'h400, 1'b1);
      compare_mem();
      reg_read(REG_DAR, d);
      check_value("dar", d, last_d);
      reg_read(REG_CCR, d);
      check_value("ccr append", {31'd0, d[CCR_APPEND_BIT]}, 32'd0);

      // source in the err window
      put_desc(32'h500, 32'hc000, 32'h2600, 32'h8000_0004, 32'd0);
      start_chain(32'h500, 32'd0);
      wait_idle(st);
      last_d = dma_copy_ref(32'h500, 1'b0);
      compare_mem();
      check_value("status", st, (32'(ST_ERR) << 8) | 32'h4);   // error state, bus error

      if (err_count == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

/* dma_top.f */
logic/dma_pkg.sv
logic/dma_csr.sv
logic/sg_engine.sv
logic/dma_top.sv
verification/tb_clock.sv
verification/wb_mem_model.sv
verification/dma_tb.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= dma_tb
RTL_TOP   ?= dma_top
FLIST     ?= dma_top.f
OBJ_DIR   ?= obj_dir
RTL_SRCS  ?= logic/dma_pkg.sv logic/dma_csr.sv logic/sg_engine.sv logic/dma_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
